//--- common/board_pkg.sv
// Shared definitions for the board shell
// Vector types for fan setting and SPI host pins
// Default divider and prescaler values

package board_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Fan speed setting, in PWM slots out of FanSlots
  typedef logic [3:0] fan_setting_t;

  // SPI chip selects from the SoC, bit 0 goes to the SD slot
  typedef logic [1:0] spi_cs_t;

  // SPI data lanes and their output enables
  typedef logic [3:0] spi_lanes_t;

  //////////////////////////////////////////////////
  // Fan PWM
  //////////////////////////////////////////////////

  // Slots per fan period, one per setting step
  localparam int unsigned FanSlots = 16;

  // soc_clk cycles per PWM slot
  localparam int unsigned DefaultFanPrescale = 1024;

  //////////////////////////////////////////////////
  // RTC
  //////////////////////////////////////////////////

  // soc_clk cycles per RTC period, 50 MHz down to 1 MHz
  localparam int unsigned DefaultRtcDivide = 50;

endpackage

//--- logic/reset_sync.sv
// Reset synchroniser for the SoC domain
// Asynchronous assertion, release after two soc_clk edges
// Test mode hands the raw board reset straight through

module reset_sync (
  input  logic soc_clk,
  input  logic cpu_resetn_i,
  input  logic testmode_i,
  output logic rst_no
);

  // Two-flop chain, ones shift in once the button is released
  logic [1:0] sync_q;

  always_ff @(posedge soc_clk or negedge cpu_resetn_i) begin
    if (!cpu_resetn_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan needs direct control of the reset net
  assign rst_no = testmode_i ? cpu_resetn_i : sync_q[1];

endmodule

//--- logic/rtc_divider.sv
// Real-time-clock divider
// Toggles rtc_o every RtcDivide/2 soc_clk cycles

module rtc_divider #(
  // soc_clk cycles per RTC period, even and at least 4
  parameter int unsigned RtcDivide = board_pkg::DefaultRtcDivide
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam int unsigned HalfPeriod = RtcDivide / 2;
  localparam int unsigned CntWidth   = $clog2(HalfPeriod);

  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] count_d;
  logic                wrap;
  logic                rtc_q;

  //////////////////////////////////////////////////
  // Half-period counter
  //////////////////////////////////////////////////

  always_comb begin
    wrap    = (count_q == CntWidth'(HalfPeriod - 1));
    count_d = wrap ? '0 : count_q + 1'b1;
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      rtc_q   <= 1'b0;
    end else begin
      count_q <= count_d;
      // One edge of the square wave per wrap
      if (wrap) begin
        rtc_q <= ~rtc_q;
      end
    end
  end

  assign rtc_o = rtc_q;

endmodule

//--- fan/fan_ctrl.sv
// PWM fan controller
// Prescaler, 16-slot period counter and duty compare
// Setting is taken over only at the start of a period

module fan_ctrl #(
  // soc_clk cycles per PWM slot, at least 1
  parameter int unsigned FanPrescale = board_pkg::DefaultFanPrescale
) (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  board_pkg::fan_setting_t fan_sw_i,
  output logic                   fan_pwm_o
);

  // Keep a one-bit counter even when no prescaling is asked for
  localparam int unsigned PreWidth = (FanPrescale > 1) ? $clog2(FanPrescale) : 1;

  logic [PreWidth-1:0]     pre_q;
  logic [PreWidth-1:0]     pre_d;
  board_pkg::fan_setting_t slot_q;
  board_pkg::fan_setting_t slot_d;
  board_pkg::fan_setting_t setting_q;
  board_pkg::fan_setting_t setting_next;
  logic                    pre_last;
  logic                    slot_last;
  logic                    period_start;
  logic                    pwm_d;
  logic                    pwm_q;

  //////////////////////////////////////////////////
  // Slot timing
  //////////////////////////////////////////////////

  always_comb begin
    pre_last     = (pre_q == PreWidth'(FanPrescale - 1));
    slot_last    = (slot_q == board_pkg::fan_setting_t'(board_pkg::FanSlots - 1));
    period_start = (pre_q == '0) && (slot_q == '0);

    pre_d  = pre_last ? '0 : pre_q + 1'b1;
    slot_d = slot_q;
    if (pre_last) begin
      slot_d = slot_last ? '0 : slot_q + 1'b1;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q  <= '0;
      slot_q <= '0;
    end else begin
      pre_q  <= pre_d;
      slot_q <= slot_d;
    end
  end

  //////////////////////////////////////////////////
  // Setting hold and duty compare
  //////////////////////////////////////////////////

  // Switches moving mid-period must not cut a pulse short
  assign setting_next = period_start ? fan_sw_i : setting_q;

  always_ff @(posedge soc_clk) begin
    if (period_start) begin
      setting_q <= fan_sw_i;
    end
  end

  // High for the first setting slots, so 0 never drives the fan
  assign pwm_d = (slot_q < setting_next);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_q <= 1'b0;
    end else begin
      pwm_q <= pwm_d;
    end
  end

  assign fan_pwm_o = pwm_q;

endmodule

//--- logic/sd_pad_adapter.sv
// SD card pad adapter in SPI mode
// Card-detect synchroniser and SPI host to SD pad mapping

module sd_pad_adapter (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 sd_cd_i,
  input  logic                 spi_sck_i,
  input  logic                 spi_sck_en_i,
  input  board_pkg::spi_cs_t    spi_cs_i,
  input  board_pkg::spi_cs_t    spi_cs_en_i,
  input  board_pkg::spi_lanes_t spi_sd_i,
  input  board_pkg::spi_lanes_t spi_sd_en_i,
  input  logic                 sd_dat0_i,
  output logic                 sd_sclk_o,
  output logic                 sd_cmd_o,
  output logic                 sd_dat3_o,
  output logic                 spi_miso_o
);

  logic [1:0] cd_sync_q;
  logic       card_present;

  //////////////////////////////////////////////////
  // Card detect
  //////////////////////////////////////////////////

  // Slot switch is asynchronous to soc_clk
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cd_sync_q <= 2'b00;
    end else begin
      cd_sync_q <= {cd_sync_q[0], sd_cd_i};
    end
  end

  assign card_present = cd_sync_q[1];

  //////////////////////////////////////////////////
  // Pad mapping
  //////////////////////////////////////////////////

  always_comb begin
    // Idle level, pads high and no data back to the host
    sd_sclk_o  = 1'b1;
    sd_dat3_o  = 1'b1;
    sd_cmd_o   = 1'b1;
    spi_miso_o = 1'b0;
    if (card_present) begin
      // SCK to CLK, CS0 to DAT3, MOSI to CMD, DAT0 back as MISO
      sd_sclk_o  = spi_sck_en_i   ? spi_sck_i   : 1'b1;
      sd_dat3_o  = spi_cs_en_i[0] ? spi_cs_i[0] : 1'b1;
      sd_cmd_o   = spi_sd_en_i[0] ? spi_sd_i[0] : 1'b1;
      spi_miso_o = sd_dat0_i;
    end
  end

endmodule

//--- logic/board_shell.sv
// Board adaption shell around the SoC core
// Reset synchroniser, RTC divider, fan PWM and SD pad adapter

module board_shell #(
  parameter int unsigned RtcDivide   = board_pkg::DefaultRtcDivide,
  parameter int unsigned FanPrescale = board_pkg::DefaultFanPrescale
) (
  input  logic                 soc_clk,
  input  logic                 cpu_resetn_i,
  input  logic                 testmode_i,
  // Fan speed switches
  input  board_pkg::fan_setting_t fan_sw_i,
  // SD slot
  input  logic                 sd_cd_i,
  input  logic                 sd_dat0_i,
  // SPI host pins from the SoC
  input  logic                 spi_sck_i,
  input  logic                 spi_sck_en_i,
  input  board_pkg::spi_cs_t    spi_cs_i,
  input  board_pkg::spi_cs_t    spi_cs_en_i,
  input  board_pkg::spi_lanes_t spi_sd_i,
  input  board_pkg::spi_lanes_t spi_sd_en_i,
  // To the SoC and the board
  output logic                 soc_rst_n_o,
  output logic                 rtc_o,
  output logic                 fan_pwm_o,
  output logic                 sd_sclk_o,
  output logic                 sd_cmd_o,
  output logic                 sd_dat3_o,
  output logic                 spi_miso_o
);

  logic rst_n;

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  reset_sync reset_sync_inst (
    .soc_clk      ( soc_clk      ),
    .cpu_resetn_i ( cpu_resetn_i ),
    .testmode_i   ( testmode_i   ),
    .rst_no       ( rst_n        )
  );

  assign soc_rst_n_o = rst_n;

  //////////////////////////////////////////////////
  // RTC
  //////////////////////////////////////////////////

  rtc_divider #(
    .RtcDivide ( RtcDivide )
  ) rtc_divider_inst (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  //////////////////////////////////////////////////
  // Fan control
  //////////////////////////////////////////////////

  fan_ctrl #(
    .FanPrescale ( FanPrescale )
  ) fan_ctrl_inst (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( rst_n     ),
    .fan_sw_i  ( fan_sw_i  ),
    .fan_pwm_o ( fan_pwm_o )
  );

  //////////////////////////////////////////////////
  // SD card in SPI mode
  //////////////////////////////////////////////////

  sd_pad_adapter sd_pad_adapter_inst (
    .soc_clk      ( soc_clk      ),
    .rst_n        ( rst_n        ),
    .sd_cd_i      ( sd_cd_i      ),
    .spi_sck_i    ( spi_sck_i    ),
    .spi_sck_en_i ( spi_sck_en_i ),
    .spi_cs_i     ( spi_cs_i     ),
    .spi_cs_en_i  ( spi_cs_en_i  ),
    .spi_sd_i     ( spi_sd_i     ),
    .spi_sd_en_i  ( spi_sd_en_i  ),
    .sd_dat0_i    ( sd_dat0_i    ),
    .sd_sclk_o    ( sd_sclk_o    ),
    .sd_cmd_o     ( sd_cmd_o     ),
    .sd_dat3_o    ( sd_dat3_o    ),
    .spi_miso_o   ( spi_miso_o   )
  );

endmodule

//--- verification/board_shell_chk.sv
// Concurrent assertions on the board shell top level
// Bound to board_shell below the module

module board_shell_chk (
  input logic soc_clk,
  input logic cpu_resetn_i,
  input logic testmode_i,
  input logic sd_cd_i,
  input logic soc_rst_n_o,
  input logic rtc_o,
  input logic fan_pwm_o,
  input logic sd_sclk_o,
  input logic sd_cmd_o,
  input logic sd_dat3_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Divider and PWM stay quiet in reset
  quiet_in_reset: assert property (
    @(posedge soc_clk) !soc_rst_n_o |-> (!rtc_o && !fan_pwm_o)
  ) else $error("rtc_o or fan_pwm_o high while soc_rst_n_o is low");

  button_holds_reset: assert property (
    @(posedge soc_clk) !cpu_resetn_i |-> !soc_rst_n_o
  ) else $error("soc_rst_n_o high while cpu_resetn_i is low");

  // Release needs two edges of a high button
  release_after_two_edges: assert property (
    @(posedge soc_clk) disable iff (testmode_i)
      $rose(soc_rst_n_o) |-> ($past(cpu_resetn_i, 1) && $past(cpu_resetn_i, 2))
  ) else $error("soc_rst_n_o released too early");

  // Present flag is card detect two edges back
  idle_pads_without_card: assert property (
    @(posedge soc_clk) disable iff (!soc_rst_n_o)
      !$past(sd_cd_i, 2) |-> (sd_sclk_o && sd_cmd_o && sd_dat3_o)
  ) else $error("SD pad driven while no card is present");

endmodule

bind board_shell board_shell_chk board_shell_chk_inst (
  .soc_clk      ( soc_clk      ),
  .cpu_resetn_i ( cpu_resetn_i ),
  .testmode_i   ( testmode_i   ),
  .sd_cd_i      ( sd_cd_i      ),
  .soc_rst_n_o  ( soc_rst_n_o  ),
  .rtc_o        ( rtc_o        ),
  .fan_pwm_o    ( fan_pwm_o    ),
  .sd_sclk_o    ( sd_sclk_o    ),
  .sd_cmd_o     ( sd_cmd_o     ),
  .sd_dat3_o    ( sd_dat3_o    )
);

//--- verification/board_shell_tb.sv
// Testbench for the board shell
// Clock and reset, stimulus, reference functions and compare tasks
// Cycle-count timeout

module board_shell_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          RtcDivide     = 10;
  localparam int          FanPrescale   = 3;
  localparam int          FanPeriod     = int'(board_pkg::FanSlots) * FanPrescale;
  // rst_n is released on the second edge after the button
  localparam int          ReleaseEdges  = 2;
  localparam int          TimeoutCycles = 3000;
  localparam int unsigned RandSeed      = 32'h8a843434;

  logic                    soc_clk = 1'b0;
  logic                    cpu_resetn_i;
  logic                    testmode_i;
  board_pkg::fan_setting_t fan_sw_i;
  logic                    sd_cd_i;
  logic                    sd_dat0_i;
  logic                    spi_sck_i;
  logic                    spi_sck_en_i;
  board_pkg::spi_cs_t      spi_cs_i;
  board_pkg::spi_cs_t      spi_cs_en_i;
  board_pkg::spi_lanes_t   spi_sd_i;
  board_pkg::spi_lanes_t   spi_sd_en_i;
  logic                    soc_rst_n_o;
  logic                    rtc_o;
  logic                    fan_pwm_o;
  logic                    sd_sclk_o;
  logic                    sd_cmd_o;
  logic                    sd_dat3_o;
  logic                    spi_miso_o;

  logic       sd_check_en;
  logic       sd_present_exp;
  logic [3:0] pads_exp;
  int         cycle_count = 0;
  int         rel_edges   = 0;

  board_shell #(
    .RtcDivide   ( RtcDivide   ),
    .FanPrescale ( FanPrescale )
  ) board_shell_inst (
    .soc_clk      ( soc_clk      ),
    .cpu_resetn_i ( cpu_resetn_i ),
    .testmode_i   ( testmode_i   ),
    .fan_sw_i     ( fan_sw_i     ),
    .sd_cd_i      ( sd_cd_i      ),
    .sd_dat0_i    ( sd_dat0_i    ),
    .spi_sck_i    ( spi_sck_i    ),
    .spi_sck_en_i ( spi_sck_en_i ),
    .spi_cs_i     ( spi_cs_i     ),
    .spi_cs_en_i  ( spi_cs_en_i  ),
    .spi_sd_i     ( spi_sd_i     ),
    .spi_sd_en_i  ( spi_sd_en_i  ),
    .soc_rst_n_o  ( soc_rst_n_o  ),
    .rtc_o        ( rtc_o        ),
    .fan_pwm_o    ( fan_pwm_o    ),
    .sd_sclk_o    ( sd_sclk_o    ),
    .sd_cmd_o     ( sd_cmd_o     ),
    .sd_dat3_o    ( sd_dat3_o    ),
    .spi_miso_o   ( spi_miso_o   )
  );

  always #5 soc_clk = ~soc_clk;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic int fan_duty(input board_pkg::fan_setting_t setting);
    return int'(setting) * FanPrescale;
  endfunction

  function automatic int rtc_half();
    return RtcDivide / 2;
  endfunction

  // Pads as {sclk, cmd, dat3, miso}
  function automatic logic [3:0] sd_map(input logic present, input logic sck,
                                        input logic sck_en, input board_pkg::spi_cs_t cs,
                                        input board_pkg::spi_cs_t cs_en,
                                        input board_pkg::spi_lanes_t lanes,
                                        input board_pkg::spi_lanes_t lanes_en,
                                        input logic dat0);
    logic sclk;
    logic cmd;
    logic dat3;
    if (!present) begin
      return 4'b1110;
    end
    sclk = sck_en ? sck : 1'b1;
    cmd  = lanes_en[0] ? lanes[0] : 1'b1;
    dat3 = cs_en[0] ? cs[0] : 1'b1;
    return {sclk, cmd, dat3, dat0};
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_setting(input string name, input board_pkg::fan_setting_t got,
                               input board_pkg::fan_setting_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_on_error($sformatf("MISMATCH time=%0t signal=%s got=%0d expected=%0d",
                              $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Timing helpers
  //////////////////////////////////////////////////

  always @(posedge soc_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      stop_on_error($sformatf("Timeout, run went past %0d cycles", TimeoutCycles));
    end
  end

  // Edges since the button was released
  always @(posedge soc_clk) begin
    if (!cpu_resetn_i) begin
      rel_edges <= 0;
    end else begin
      rel_edges <= rel_edges + 1;
    end
  end

  // The first fan period starts on the edge after rst_n rises
  task automatic wait_period_start();
    while (!(rel_edges >= ReleaseEdges && (rel_edges - ReleaseEdges) % FanPeriod == 0)) begin
      @(negedge soc_clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Reset and RTC
  //////////////////////////////////////////////////

  task automatic apply_reset_and_check();
    testmode_i   = 1'b0;
    cpu_resetn_i = 1'b0;
    #2;
    check_bit("soc_rst_n_o", soc_rst_n_o, 1'b0);
    repeat (2) @(negedge soc_clk);
    cpu_resetn_i = 1'b1;
    @(negedge soc_clk);
    // Held for one edge after release
    check_bit("soc_rst_n_o", soc_rst_n_o, 1'b0);
    @(negedge soc_clk);
    check_bit("soc_rst_n_o", soc_rst_n_o, 1'b1);
    check_bit("rtc_o", rtc_o, 1'b0);
    check_bit("fan_pwm_o", fan_pwm_o, 1'b0);
  endtask

  // No clock edge between drive and check
  task automatic run_testmode_test();
    int n;
    testmode_i = 1'b1;
    for (n = 0; n < 2; n++) begin
      cpu_resetn_i = 1'b0;
      #2;
      check_bit("soc_rst_n_o", soc_rst_n_o, 1'b0);
      @(negedge soc_clk);
      cpu_resetn_i = 1'b1;
      #2;
      check_bit("soc_rst_n_o", soc_rst_n_o, 1'b1);
      @(negedge soc_clk);
    end
  endtask

  task automatic measure_phase(input logic level, output int len);
    len = 0;
    while (rtc_o === level) begin
      len++;
      @(negedge soc_clk);
    end
  endtask

  task automatic run_rtc_test();
    int   phase_len;
    int   p;
    logic level;
    level = 1'b0;
    // Low phase out of reset, then five full periods
    for (p = 0; p < 11; p++) begin
      measure_phase(level, phase_len);
      check_count("rtc_o phase length", phase_len, rtc_half());
      level = ~level;
    end
  endtask

  //////////////////////////////////////////////////
  // Fan PWM
  //////////////////////////////////////////////////

  task automatic measure_fan_period(input int change_at, input board_pkg::fan_setting_t later,
                                    output int high_count);
    int i;
    high_count = 0;
    for (i = 0; i < FanPeriod; i++) begin
      @(negedge soc_clk);
      if (fan_pwm_o) begin
        high_count++;
      end
      if (i == change_at) begin
        fan_sw_i = later;
      end
    end
  endtask

  task automatic check_fan_period(input board_pkg::fan_setting_t setting, input int high_count);
    if ((high_count % FanPrescale) != 0 ||
        high_count > (int'(board_pkg::FanSlots) - 1) * FanPrescale) begin
      stop_on_error($sformatf("fan_pwm_o was high for %0d cycles, not a valid slot count",
                              high_count));
    end else begin
      check_setting("fan_pwm_o", board_pkg::fan_setting_t'(high_count / FanPrescale),
                    board_pkg::fan_setting_t'(fan_duty(setting) / FanPrescale));
    end
  endtask

  task automatic run_fan_test();
    board_pkg::fan_setting_t settings [8];
    board_pkg::fan_setting_t first;
    board_pkg::fan_setting_t second;
    int                      high_count;
    int                      n;
    settings[0] = 4'd0;
    settings[1] = 4'd15;
    for (n = 2; n < 8; n++) begin
      settings[n] = board_pkg::fan_setting_t'($urandom_range(14, 1));
    end
    for (n = 0; n < 8; n++) begin
      wait_period_start();
      fan_sw_i = settings[n];
      measure_fan_period(-1, settings[n], high_count);
      check_fan_period(settings[n], high_count);
    end
    // Switches drop from a high to a low setting in the middle of a period
    first  = board_pkg::fan_setting_t'($urandom_range(14, 8));
    second = board_pkg::fan_setting_t'($urandom_range(7, 1));
    wait_period_start();
    fan_sw_i = first;
    measure_fan_period(FanPeriod / 3, second, high_count);
    check_fan_period(first, high_count);
    wait_period_start();
    measure_fan_period(-1, second, high_count);
    check_fan_period(second, high_count);
  endtask

  //////////////////////////////////////////////////
  // SD pads
  //////////////////////////////////////////////////

  // Expected present flag holds until the next rising edge
  task automatic drive_sd_cycle(input logic cd, input logic present);
    @(negedge soc_clk);
    sd_cd_i        = cd;
    sd_present_exp = present;
    spi_sck_i      = 1'($urandom());
    spi_sck_en_i   = 1'($urandom());
    spi_cs_i       = board_pkg::spi_cs_t'($urandom());
    spi_cs_en_i    = board_pkg::spi_cs_t'($urandom());
    spi_sd_i       = board_pkg::spi_lanes_t'($urandom());
    spi_sd_en_i    = board_pkg::spi_lanes_t'($urandom());
    sd_dat0_i      = 1'($urandom());
  endtask

  task automatic run_sd_test();
    drive_sd_cycle(1'b1, 1'b0);
    sd_check_en = 1'b1;
    drive_sd_cycle(1'b1, 1'b0);
    drive_sd_cycle(1'b1, 1'b1);
    repeat (150) drive_sd_cycle(1'b1, 1'b1);
    // Card pulled, idle from the second edge on
    drive_sd_cycle(1'b0, 1'b1);
    drive_sd_cycle(1'b0, 1'b1);
    repeat (30) drive_sd_cycle(1'b0, 1'b0);
    drive_sd_cycle(1'b1, 1'b0);
    drive_sd_cycle(1'b1, 1'b0);
    repeat (30) drive_sd_cycle(1'b1, 1'b1);
    @(negedge soc_clk);
    sd_check_en = 1'b0;
  endtask

  // Pads sampled just before each rising edge
  always @(posedge soc_clk) begin
    if (sd_check_en) begin
      pads_exp = sd_map(sd_present_exp, spi_sck_i, spi_sck_en_i, spi_cs_i, spi_cs_en_i,
                        spi_sd_i, spi_sd_en_i, sd_dat0_i);
      check_bit("sd_sclk_o", sd_sclk_o, pads_exp[3]);
      check_bit("sd_cmd_o", sd_cmd_o, pads_exp[2]);
      check_bit("sd_dat3_o", sd_dat3_o, pads_exp[1]);
      check_bit("spi_miso_o", spi_miso_o, pads_exp[0]);
    end
  end

  initial begin
    void'($urandom(RandSeed));
    cpu_resetn_i   = 1'b0;
    testmode_i     = 1'b0;
    fan_sw_i       = '0;
    sd_cd_i        = 1'b0;
    sd_dat0_i      = 1'b0;
    spi_sck_i      = 1'b0;
    spi_sck_en_i   = 1'b0;
    spi_cs_i       = '0;
    spi_cs_en_i    = '0;
    spi_sd_i       = '0;
    spi_sd_en_i    = '0;
    sd_check_en    = 1'b0;
    sd_present_exp = 1'b0;
    apply_reset_and_check();
    run_testmode_test();
    apply_reset_and_check();
    run_rtc_test();
    run_fan_test();
    run_sd_test();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- sim.f
common/board_pkg.sv
logic/reset_sync.sv
logic/rtc_divider.sv
fan/fan_ctrl.sv
logic/sd_pad_adapter.sv
logic/board_shell.sv
verification/board_shell_chk.sv
verification/board_shell_tb.sv

//--- Makefile
# Verilator build and run for the board shell testbench

TOP := board_shell_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
